// File: Bender.yml
package:
  name: fma_unit

sources:
  - source/fma_pkg.sv
  - source/fma_operands_if.sv
  - source/fma_aligned_if.sv
  - source/fma_operand_prep.sv
  - source/fma_special_case.sv
  - source/fma_align_stage.sv
  - source/fma_lzc.sv
  - source/fma_normalize_stage.sv
  - source/fma_unit.sv
  - target: simulation
    files:
      - sim/fma_unit_tb.sv

// File: build.f
source/fma_pkg.sv
source/fma_operands_if.sv
source/fma_aligned_if.sv
source/fma_operand_prep.sv
source/fma_special_case.sv
source/fma_align_stage.sv
source/fma_lzc.sv
source/fma_normalize_stage.sv
source/fma_unit.sv
sim/fma_unit_tb.sv

// File: sim/fma_unit_tb.sv
/*
 * FMA unit testbench
 * Reads operations and expected pre-round results from the vector file,
 * issues them to the DUT and checks every result and its arrival cycle
 */
module fma_unit_tb;
  import fma_pkg::*;

  localparam int max_lines = 64;

  logic          clock;
  logic          reset;
  logic          clear;
  logic          in_valid;
  fma_op_t       op;
  fp_fmt_t       fmt;
  fp_operand_t   operand_a;
  fp_operand_t   operand_b;
  fp_operand_t   operand_c;
  logic          out_valid;
  logic          result_sign;
  exponent_t     result_exponent;
  rnd_mantissa_t result_mantissa;
  grs_t          result_grs;
  logic          flag_snan;
  logic          flag_qnan;
  logic          flag_infs;
  logic          flag_zero;
  logic          flag_diff;

  // One row per vector line with the columns of the file
  logic [64:0] vec [0:max_lines-1][0:15];
  int          num_lines = 0;
  logic        loaded    = 1'b0;
  int          cycle     = 0;
  int          errors    = 0;
  int          pending_line[$];   // Line index of each result in flight
  int          pending_cycle[$];  // Cycle at which it must show up

  fma_unit i_fma_unit (
    .clock           (clock),
    .reset           (reset),
    .clear           (clear),
    .in_valid        (in_valid),
    .op              (op),
    .fmt             (fmt),
    .operand_a       (operand_a),
    .operand_b       (operand_b),
    .operand_c       (operand_c),
    .out_valid       (out_valid),
    .result_sign     (result_sign),
    .result_exponent (result_exponent),
    .result_mantissa (result_mantissa),
    .result_grs      (result_grs),
    .flag_snan       (flag_snan),
    .flag_qnan       (flag_qnan),
    .flag_infs       (flag_infs),
    .flag_zero       (flag_zero),
    .flag_diff       (flag_diff)
  );

  always #20 clock = ~clock;

  always @(posedge clock) cycle <= cycle + 1;

  task automatic check_value(input string name, input logic [64:0] actual,
                             input logic [64:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("error at time %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic load_vectors();
    int    fd;
    int    code;
    string line;
    fd = $fopen("sim/fma_unit_vectors.txt", "r");
    if (fd == 0) begin
      $display("The vector file could not be opened");
      $display("Simulation failed");
      $fatal(1);
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      if (line.len() < 2 || line.substr(0, 1) == "//")
        continue;                          // Blank or comment line
      code = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                     vec[num_lines][0], vec[num_lines][1], vec[num_lines][2],
                     vec[num_lines][3], vec[num_lines][4], vec[num_lines][5],
                     vec[num_lines][6], vec[num_lines][7], vec[num_lines][8],
                     vec[num_lines][9], vec[num_lines][10], vec[num_lines][11],
                     vec[num_lines][12], vec[num_lines][13], vec[num_lines][14],
                     vec[num_lines][15]);
      if (code != 16) begin
        $display("A vector line does not hold sixteen fields");
        $display("Simulation failed");
        $fatal(1);
      end
      num_lines++;
    end
    $fclose(fd);
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  initial begin
    clock     = 1'b0;
    reset     = 1'b0;
    clear     = 1'b0;
    in_valid  = 1'b0;
    op        = fmadd;
    fmt       = fmt_double;
    operand_a = '0;
    operand_b = '0;
    operand_c = '0;
    load_vectors();
    loaded = 1'b1;

    repeat (5) @(posedge clock);
    reset <= 1'b1;

    for (int i = 0; i < num_lines; i++) begin
      for (int g = 0; g < int'(vec[i][0]); g++) begin
        @(posedge clock);                  // Idle gap
        in_valid <= 1'b0;
        clear    <= 1'b0;
      end
      @(posedge clock);
      in_valid  <= 1'b1;
      clear     <= vec[i][6][0];
      op        <= fma_op_t'(vec[i][1][2:0]);
      fmt       <= fp_fmt_t'(vec[i][2][1:0]);
      operand_a <= vec[i][3];
      operand_b <= vec[i][4];
      operand_c <= vec[i][5];
      if (!vec[i][6][0]) begin           // Cleared lines expect nothing
        pending_line.push_back(i);
        pending_cycle.push_back(cycle + 3);
      end
    end
    @(posedge clock);
    in_valid <= 1'b0;
    clear    <= 1'b0;

    while (pending_line.size() != 0) @(negedge clock);
    repeat (4) @(negedge clock);         // Catch any stray strobe
    if (errors == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1);
    end
  end

  // ==========================================================================
  // Result checks at the falling edge
  // ==========================================================================
  always @(negedge clock) begin
    int idx;
    int due;
    if (out_valid === 1'b1) begin
      if (pending_line.size() == 0) begin
        $display("The DUT raised out_valid with no operation pending");
        $display("Simulation failed");
        $fatal(1);
      end
      idx = pending_line.pop_front();
      due = pending_cycle.pop_front();
      check_value("out_valid cycle", cycle, due);
      check_value("result_sign", result_sign, vec[idx][7]);
      check_value("result_exponent", $unsigned(result_exponent), vec[idx][8]);
      check_value("result_mantissa", result_mantissa, vec[idx][9]);
      check_value("result_grs", result_grs, vec[idx][10]);
      check_value("flag_snan", flag_snan, vec[idx][11]);
      check_value("flag_qnan", flag_qnan, vec[idx][12]);
      check_value("flag_infs", flag_infs, vec[idx][13]);
      check_value("flag_zero", flag_zero, vec[idx][14]);
      check_value("flag_diff", flag_diff, vec[idx][15]);
    end
  end

  // Watchdog sized from the number of vector lines
  initial begin
    wait (loaded);
    #(40 * (num_lines * 4 + 50));
    $display("The DUT stopped producing results before all expected ones arrived");
    $display("Simulation failed");
    $fatal(1);
  end

endmodule

// File: sim/fma_unit_vectors.txt
// gap op fmt operand_a operand_b operand_c clear | sign exponent mantissa grs snan qnan infs zero diff
// op: 0 fmadd 1 fmsub 2 fnmadd 3 fnmsub 4 fadd 5 fsub 6 fmul, fmt: 0 double 1 single
2 0 0 07FF0000000000000 07FF0000000000000 07FF0000000000000 0 0 03FF 10000000000000 0 0 0 0 0 0
0 1 0 07FF0000000000000 07FF0000000000000 07FE0000000000000 0 0 03FD 10000000000000 0 0 0 0 0 1
0 0 0 07FF0000000000000 07FF0000000000000 08010000000000000 0 0 0400 14000000000000 0 0 0 0 0 0
0 2 0 07FF8000000000000 07FF0000000000000 07FF0000000000000 0 1 03FF 14000000000000 0 0 0 0 0 0
1 3 0 08000000000000000 07FF0000000000000 07FF0000000000000 0 1 03FE 10000000000000 0 0 0 0 0 1
0 4 0 07FF0000000000000 07FF0000000000000 00000000000000000 0 0 03FF 10000000000000 0 0 0 0 0 0
0 5 0 07FF0000000000000 07FE0000000000000 00000000000000000 0 0 03FD 10000000000000 0 0 0 0 0 1
1 6 0 07FF8000000000000 08000000000000000 00000000000000000 0 0 03FF 18000000000000 0 0 0 0 0 0
0 0 1 07FF0000000000000 07FF0000000000000 07FF0000000000000 0 0 077F 800000 0 0 0 0 0 0
0 6 1 07FF0000010000001 07FF0000000000000 00000000000000000 0 0 077E 800000 5 0 0 0 0 0
0 6 1 00800000000000000 07FF0000000000000 00000000000000000 0 0 0000 200000 0 0 0 0 0 0
2 0 0 0FFF0000000000001 07FF0000000000000 07FF0000000000000 0 0 0BFE 10000000000001 1 1 0 0 0 0
0 0 0 0FFF0000000000000 00000000000000000 07FF0000000000000 0 0 0B92 10000000000000 0 1 0 0 0 0
0 0 0 07FF0000000000000 07FF0000000000000 0FFF8000000000000 0 0 0BFE 18000000000000 1 0 1 0 0 0
0 1 0 0FFF0000000000000 07FF8000000000000 0FFF0000000000000 0 0 0BFD 10000000000000 0 1 0 0 0 1
0 0 0 0FFF0000000000000 07FF0000000000000 07FF0000000000000 0 0 0BFE 10000000000000 1 0 0 1 0 0
1 1 0 07FF0000000000000 07FF0000000000000 07FF0000000000000 0 0 035D 0 0 0 0 0 1 1
0 2 0 00000000000000000 00000000000000000 00000000000000000 0 1 0000 0 0 0 0 0 1 0
1 0 0 07FF0000000000000 07FF0000000000000 07FF0000000000000 1 0 0000 0 0 0 0 0 0 0
0 1 0 07FF0000000000000 07FF0000000000000 07FE0000000000000 0 0 03FD 10000000000000 0 0 0 0 0 1
0 0 0 07FF0000000000000 07FF0000000000000 08010000000000000 0 0 0400 14000000000000 0 0 0 0 0 0

// File: source/fma_align_stage.sv
/*
 * Stage 1 of the FMA
 * Leg exponents, mantissa product and alignment of the smaller leg,
 * registered into the aligned bundle
 */
module fma_align_stage (
  input  logic          clock,
  input  logic          reset,
  input  logic          clear,
  fma_operands_if.sink  operands,
  input  logic          flag_snan,
  input  logic          flag_qnan,
  input  logic          flag_infs,
  fma_aligned_if.source aligned
);
  import fma_pkg::*;

  exponent_t      exponent_add;
  exponent_t      exponent_mul;
  exponent_t      exponent_dif;
  logic           exponent_neg;   // Addend leg dominates
  logic [105:0]   product;
  logic [6:0]     shift_count;
  wide_mantissa_t lane_mul;
  wide_mantissa_t lane_add;
  wide_mantissa_t next_mul;
  wide_mantissa_t next_add;

  // =========================================================================
  // Exponents and product
  // =========================================================================
  always_comb begin
    exponent_add = exponent_t'({2'b00, operands.exponent_c});  // Special C stays at 4095
    exponent_mul = exponent_t'({2'b00, operands.exponent_a})
                 + exponent_t'({2'b00, operands.exponent_b}) - recode_offset;
    if (operands.exponent_a == special_exponent[11:0] ||
        operands.exponent_b == special_exponent[11:0])
      exponent_mul = special_exponent;
  end

  assign product  = operands.mantissa_a * operands.mantissa_b;
  assign lane_mul = {2'b00, product, 56'd0};
  assign lane_add = {3'b000, operands.mantissa_c, 108'd0};

  assign exponent_dif = exponent_mul - exponent_add;
  assign exponent_neg = exponent_dif[13];

  // =========================================================================
  // Alignment of the smaller leg
  // =========================================================================
  always_comb begin
    if (exponent_neg) begin
      shift_count = (exponent_dif > -align_left_limit) ? 7'(-exponent_dif)
                                                        : 7'(align_left_limit);
      next_mul = lane_mul >> shift_count;
      next_add = lane_add;
    end else begin
      shift_count = (exponent_dif < align_right_limit) ? 7'(exponent_dif)
                                                        : 7'(align_right_limit);
      next_mul = lane_mul;
      next_add = lane_add >> shift_count;
    end
  end

  // Control part of the stage register
  always_ff @(posedge clock) begin
    if (!reset) begin
      aligned.valid     <= 1'b0;
      aligned.flag_snan <= 1'b0;
      aligned.flag_qnan <= 1'b0;
      aligned.flag_infs <= 1'b0;
    end else begin
      aligned.valid     <= operands.valid & ~clear;
      aligned.flag_snan <= flag_snan;
      aligned.flag_qnan <= flag_qnan;
      aligned.flag_infs <= flag_infs;
    end
  end

  // Payload part
  always_ff @(posedge clock) begin
    aligned.fmt          <= operands.fmt;
    aligned.sign_mul     <= operands.sign_mul;
    aligned.sign_add     <= operands.sign_add;
    aligned.exponent_mac <= exponent_neg ? exponent_add : exponent_mul;
    aligned.mant_mul     <= next_mul;
    aligned.mant_add     <= next_add;
  end

endmodule

// File: source/fma_aligned_if.sv
/*
 * Stage 1 to stage 2 bundle
 * Registered aligned lanes, leg signs, dominant exponent and the special
 * case flags of one operation
 */
interface fma_aligned_if;
  import fma_pkg::*;

  logic           valid;
  fp_fmt_t        fmt;
  logic           sign_mul;
  logic           sign_add;
  exponent_t      exponent_mac;  // Exponent of the dominant leg
  wide_mantissa_t mant_mul;
  wide_mantissa_t mant_add;
  logic           flag_snan;
  logic           flag_qnan;
  logic           flag_infs;

  modport source (
    output valid, fmt, sign_mul, sign_add, exponent_mac, mant_mul, mant_add,
           flag_snan, flag_qnan, flag_infs
  );

  modport sink (
    input valid, fmt, sign_mul, sign_add, exponent_mac, mant_mul, mant_add,
          flag_snan, flag_qnan, flag_infs
  );

endinterface

// File: source/fma_lzc.sv
/*
 * Leading zero counter
 * Counts the leading zeros of the sum magnitude below the sign bit
 */
module fma_lzc (
  input  fma_pkg::wide_mantissa_t vector,
  output fma_pkg::lzc_count_t     count
);
  import fma_pkg::*;

  wide_mantissa_t padded;

  // Trailing one keeps the count bounded for a zero input
  assign padded = {vector[$bits(wide_mantissa_t)-2:0], 1'b1};

  // Highest set bit wins, as it is visited last
  always_comb begin
    count = '0;
    for (int i = 0; i < $bits(wide_mantissa_t); i++) begin
      if (padded[i])
        count = lzc_count_t'($bits(wide_mantissa_t) - 1 - i);
    end
  end

endmodule

// File: source/fma_normalize_stage.sv
/*
 * Stage 2 of the FMA
 * Signed add of both legs, normalization, subnormal shift and extraction
 * of the pre-round mantissa with guard, round and sticky bits
 */
module fma_normalize_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   clear,
  fma_aligned_if.sink            aligned,
  output logic                   out_valid,
  output logic                   result_sign,
  output fma_pkg::exponent_t     result_exponent,
  output fma_pkg::rnd_mantissa_t result_mantissa,
  output fma_pkg::grs_t          result_grs,
  output logic                   flag_snan,
  output logic                   flag_qnan,
  output logic                   flag_infs,
  output logic                   flag_zero,
  output logic                   flag_diff
);
  import fma_pkg::*;

  wide_mantissa_t lane_add;
  wide_mantissa_t lane_mul;
  wide_mantissa_t sum;
  wide_mantissa_t magnitude;
  wide_mantissa_t normalized;
  wide_mantissa_t shifted;
  logic           sum_zero;
  logic           sign_rnd;
  lzc_count_t     count;
  exponent_t      bias;
  exponent_t      exponent_rnd;
  logic [5:0]     sub_shift;
  rnd_mantissa_t  mantissa_rnd;
  grs_t           grs;

  // =========================================================================
  // Two's complement sum and magnitude
  // =========================================================================
  always_comb begin
    lane_add = aligned.sign_add ? ~aligned.mant_add + 1'b1 : aligned.mant_add;
    lane_mul = aligned.sign_mul ? ~aligned.mant_mul + 1'b1 : aligned.mant_mul;
    sum      = lane_add + lane_mul;
    sum_zero = (sum == '0);
    if (sum_zero)
      sign_rnd = aligned.sign_add & aligned.sign_mul;  // Exact zero sign rule
    else
      sign_rnd = sum[163];
    magnitude = sum[163] ? -sum : sum;
  end

  fma_lzc i_fma_lzc (
    .vector (magnitude),
    .count  (count)
  );

  // =========================================================================
  // Normalization and extraction
  // =========================================================================
  always_comb begin
    bias         = (aligned.fmt == fmt_single) ? single_bias : double_bias;
    exponent_rnd = aligned.exponent_mac - bias - exponent_t'({6'd0, count});
    normalized   = magnitude << count;

    // Subnormal result
    sub_shift = '0;
    if (exponent_rnd <= 0) begin
      if (exponent_rnd > -subnormal_limit)
        sub_shift = 6'(1 - exponent_rnd);
      else
        sub_shift = 6'(subnormal_limit);
      exponent_rnd = '0;
    end
    shifted = normalized >> sub_shift;

    if (aligned.fmt == fmt_single) begin
      mantissa_rnd = {30'd0, shifted[162:139]};
      grs          = {shifted[138:137], |shifted[136:0]};
    end else begin
      mantissa_rnd = {1'b0, shifted[162:110]};
      grs          = {shifted[109:108], |shifted[107:0]};
    end
  end

  // Control and flags
  always_ff @(posedge clock) begin
    if (!reset) begin
      out_valid <= 1'b0;
      flag_snan <= 1'b0;
      flag_qnan <= 1'b0;
      flag_infs <= 1'b0;
      flag_zero <= 1'b0;
      flag_diff <= 1'b0;
    end else begin
      out_valid <= aligned.valid & ~clear;
      flag_snan <= aligned.flag_snan;
      flag_qnan <= aligned.flag_qnan;
      flag_infs <= aligned.flag_infs;
      flag_zero <= sum_zero;
      flag_diff <= aligned.sign_add ^ aligned.sign_mul;  // Effective subtraction
    end
  end

  always_ff @(posedge clock) begin
    result_sign     <= sign_rnd;
    result_exponent <= exponent_rnd;
    result_mantissa <= mantissa_rnd;
    result_grs      <= grs;
  end

endmodule

// File: source/fma_operand_prep.sv
/*
 * Operand preparation
 * Turns add, sub and mul into the fused form, unpacks the three operands
 * and works out the product and addend signs
 */
module fma_operand_prep (
  input  logic                in_valid,
  input  fma_pkg::fma_op_t    op,
  input  fma_pkg::fp_fmt_t    fmt,
  input  fma_pkg::fp_operand_t operand_a,
  input  fma_pkg::fp_operand_t operand_b,
  input  fma_pkg::fp_operand_t operand_c,
  fma_operands_if.source      operands
);
  import fma_pkg::*;

  fp_operand_t fused_b;
  fp_operand_t fused_c;
  logic        neg_add;
  logic        neg_mul;

  // Hidden bit set for any nonzero exponent
  function automatic mantissa_t unpack_mantissa(fp_operand_t value);
    return {|value[63:52], value[51:0]};
  endfunction

  always_comb begin
    fused_b = operand_b;
    fused_c = operand_c;
    if (op == fadd || op == fsub) begin
      fused_c = operand_b;   // A x 1.0 +- B
      fused_b = one_operand;
    end else if (op == fmul) begin
      fused_c = {operand_a[64] ^ operand_b[64], 64'd0};  // Signed zero addend
    end
  end

  assign neg_add = (op == fmsub) || (op == fnmadd) || (op == fsub);
  assign neg_mul = (op == fnmsub) || (op == fnmadd);

  assign operands.valid      = in_valid;
  assign operands.fmt        = fmt;
  assign operands.sign_a     = operand_a[64];
  assign operands.sign_b     = fused_b[64];
  assign operands.sign_c     = fused_c[64];
  assign operands.exponent_a = operand_a[63:52];
  assign operands.exponent_b = fused_b[63:52];
  assign operands.exponent_c = fused_c[63:52];
  assign operands.mantissa_a = unpack_mantissa(operand_a);
  assign operands.mantissa_b = unpack_mantissa(fused_b);
  assign operands.mantissa_c = unpack_mantissa(fused_c);
  assign operands.quiet_a    = operand_a[51];
  assign operands.quiet_b    = fused_b[51];
  assign operands.quiet_c    = fused_c[51];

  assign operands.sign_mul = operand_a[64] ^ fused_b[64] ^ neg_mul;
  assign operands.sign_add = fused_c[64] ^ neg_add;

endmodule

// File: source/fma_operands_if.sv
/*
 * Unpacked operand bundle
 * Carries the morphed and unpacked operands from preparation to the
 * special case checks and to the alignment stage
 */
interface fma_operands_if;
  import fma_pkg::*;

  logic          valid;
  fp_fmt_t       fmt;
  logic          sign_a, sign_b, sign_c;
  raw_exponent_t exponent_a, exponent_b, exponent_c;
  mantissa_t     mantissa_a, mantissa_b, mantissa_c;
  logic          quiet_a, quiet_b, quiet_c;  // Top fraction bits
  logic          sign_mul;
  logic          sign_add;

  modport source (
    output valid, fmt, sign_a, sign_b, sign_c, exponent_a, exponent_b, exponent_c,
           mantissa_a, mantissa_b, mantissa_c, quiet_a, quiet_b, quiet_c, sign_mul, sign_add
  );

  modport sink (
    input valid, fmt, sign_a, sign_b, sign_c, exponent_a, exponent_b, exponent_c,
          mantissa_a, mantissa_b, mantissa_c, quiet_a, quiet_b, quiet_c, sign_mul, sign_add
  );

endinterface

// File: source/fma_pkg.sv
/*
 * FMA package
 * Widths, operation and format encodings and the constants shared by the
 * fused multiply-add datapath
 */
package fma_pkg;

  // =========================================================================
  // Types
  // =========================================================================
  typedef logic [64:0]        fp_operand_t;    // Sign, exponent, fraction
  typedef logic [11:0]        raw_exponent_t;
  typedef logic [52:0]        mantissa_t;      // Hidden bit on top
  typedef logic signed [13:0] exponent_t;
  typedef logic [163:0]       wide_mantissa_t; // Alignment and sum lane
  typedef logic [53:0]        rnd_mantissa_t;
  typedef logic [2:0]         grs_t;
  typedef logic [7:0]         lzc_count_t;

  typedef enum logic [2:0] {
    fmadd,
    fmsub,
    fnmadd,
    fnmsub,
    fadd,
    fsub,
    fmul
  } fma_op_t;

  typedef enum logic [1:0] {
    fmt_double = 2'd0,
    fmt_single = 2'd1
  } fp_fmt_t;

  // =========================================================================
  // Constants
  // =========================================================================
  localparam exponent_t recode_offset = 14'sd2047;
  localparam exponent_t double_bias   = 14'sd1023;
  localparam exponent_t single_bias   = 14'sd127;

  // Recoded +1.0 used when add and sub are turned into fused form
  localparam fp_operand_t one_operand = {1'b0, 12'd2047, 52'd0};

  // Infinity or NaN marker in either leg
  localparam exponent_t special_exponent = 14'sh0FFF;

  localparam int align_left_limit  = 56;  // Product leg shift cap
  localparam int align_right_limit = 108; // Addend leg shift cap
  localparam int subnormal_limit   = 63;

endpackage

// File: source/fma_special_case.sv
/*
 * Special case detection
 * Classifies the three operands and raises the exception flag of the first
 * matching rule
 */
module fma_special_case (
  fma_operands_if.sink operands,
  output logic         flag_snan,
  output logic         flag_qnan,
  output logic         flag_infs
);
  import fma_pkg::*;

  logic inf_a, snan_a, qnan_a, zero_a;
  logic inf_b, snan_b, qnan_b, zero_b;
  logic inf_c, snan_c, qnan_c;

  // Returns {infinity, signalling NaN, quiet NaN}
  function automatic logic [2:0] classify(raw_exponent_t exponent, mantissa_t mantissa,
                                          logic quiet);
    logic max_exponent;
    logic fraction_zero;
    max_exponent  = (exponent == special_exponent[11:0]);
    fraction_zero = (mantissa[51:0] == '0);
    return {max_exponent & fraction_zero, max_exponent & ~fraction_zero & ~quiet,
            max_exponent & ~fraction_zero & quiet};
  endfunction

  // Exponent and fraction both zero
  function automatic logic is_zero(raw_exponent_t exponent, mantissa_t mantissa);
    return (exponent == '0) && (mantissa[51:0] == '0);
  endfunction

  assign {inf_a, snan_a, qnan_a} =
    classify(operands.exponent_a, operands.mantissa_a, operands.quiet_a);
  assign {inf_b, snan_b, qnan_b} =
    classify(operands.exponent_b, operands.mantissa_b, operands.quiet_b);
  assign {inf_c, snan_c, qnan_c} =
    classify(operands.exponent_c, operands.mantissa_c, operands.quiet_c);

  assign zero_a = is_zero(operands.exponent_a, operands.mantissa_a);
  assign zero_b = is_zero(operands.exponent_b, operands.mantissa_b);

  always_comb begin
    flag_snan = 1'b0;
    flag_qnan = 1'b0;
    flag_infs = 1'b0;
    if (snan_a | snan_b | snan_c) begin
      flag_snan = 1'b1;
    end else if ((inf_a & zero_b) | (inf_b & zero_a)) begin
      flag_snan = 1'b1;                       // Infinity times zero
    end else if (qnan_a | qnan_b | qnan_c) begin
      flag_qnan = 1'b1;
    end else if ((inf_a | inf_b) & inf_c & (operands.sign_add != operands.sign_mul)) begin
      flag_snan = 1'b1;                       // Infinity minus infinity
    end else if (inf_a | inf_b | inf_c) begin
      flag_infs = 1'b1;
    end
  end

endmodule

// File: source/fma_unit.sv
/*
 * Fused multiply-add unit
 * Two stage (A x B) +- C datapath producing a pre-round result and the
 * exception flags, with a latency of two cycles
 */
module fma_unit (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   clear,
  input  logic                   in_valid,
  input  fma_pkg::fma_op_t       op,
  input  fma_pkg::fp_fmt_t       fmt,
  input  fma_pkg::fp_operand_t   operand_a,
  input  fma_pkg::fp_operand_t   operand_b,
  input  fma_pkg::fp_operand_t   operand_c,
  output logic                   out_valid,
  output logic                   result_sign,
  output fma_pkg::exponent_t     result_exponent,
  output fma_pkg::rnd_mantissa_t result_mantissa,
  output fma_pkg::grs_t          result_grs,
  output logic                   flag_snan,
  output logic                   flag_qnan,
  output logic                   flag_infs,
  output logic                   flag_zero,
  output logic                   flag_diff
);

  fma_operands_if operands ();
  fma_aligned_if  aligned ();

  logic special_snan;
  logic special_qnan;
  logic special_infs;

  fma_operand_prep i_fma_operand_prep (
    .in_valid  (in_valid),
    .op        (op),
    .fmt       (fmt),
    .operand_a (operand_a),
    .operand_b (operand_b),
    .operand_c (operand_c),
    .operands  (operands.source)
  );

  fma_special_case i_fma_special_case (
    .operands  (operands.sink),
    .flag_snan (special_snan),
    .flag_qnan (special_qnan),
    .flag_infs (special_infs)
  );

  // Stage 1
  fma_align_stage i_fma_align_stage (
    .clock     (clock),
    .reset     (reset),
    .clear     (clear),
    .operands  (operands.sink),
    .flag_snan (special_snan),
    .flag_qnan (special_qnan),
    .flag_infs (special_infs),
    .aligned   (aligned.source)
  );

  // Stage 2
  fma_normalize_stage i_fma_normalize_stage (
    .clock           (clock),
    .reset           (reset),
    .clear           (clear),
    .aligned         (aligned.sink),
    .out_valid       (out_valid),
    .result_sign     (result_sign),
    .result_exponent (result_exponent),
    .result_mantissa (result_mantissa),
    .result_grs      (result_grs),
    .flag_snan       (flag_snan),
    .flag_qnan       (flag_qnan),
    .flag_infs       (flag_infs),
    .flag_zero       (flag_zero),
    .flag_diff       (flag_diff)
  );

endmodule
